/* design/rvc_pkg.sv */
package rvc_pkg;

  ////////////////////////////////////////////////////////////
  // rv32 major opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // host word address map
  // 0..31 read x0..x31
  localparam int unsigned ADR_W = 6;
  localparam logic [ADR_W-1:0] ADR_INSTR  = 6'd32;
  localparam logic [ADR_W-1:0] ADR_STATUS = 6'd33;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // decode -> execute
  typedef struct packed {
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        b_imm;    // operand b from imm instead of rs2
    logic        we;
    logic        illegal;
    logic        unsup;
  } dec_payload_t;

  // execute -> result
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] result;
    logic        we;
    logic        illegal;
    logic        unsup;
  } exe_payload_t;

endpackage

/* design/rf_read_if.sv */
`timescale 1ns/1ns

// two combinational read ports into the register file
interface rf_read_if;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  // execute side drives addresses
  modport exe (output rs1_addr, output rs2_addr,
               input  rs1_data, input  rs2_data);

  // register file answers in the same cycle
  modport rf  (input  rs1_addr, input  rs2_addr,
               output rs1_data, output rs2_data);
endinterface

/* design/rvc_expand.sv */
`timescale 1ns/1ns

module rvc_expand (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);
  import rvc_pkg::*;

  logic [15:0] c;

  assign c = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    illegal_o = 1'b0;
    instr_o   = instr_i;
    unique case (c[1:0])
      ////////////////////////////////////////////////////////////
      // quadrant 0
      ////////////////////////////////////////////////////////////
      2'b00: begin
        unique case (c[15:13])
          // c.addi4spn with zero imm is reserved (covers all-zero halfword)
          3'b000: begin
            instr_o = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000,
                       2'b01, c[4:2], OPCODE_OPIMM};
            if (c[12:5] == 8'd0) illegal_o = 1'b1;
          end
          // c.lw
          3'b010: instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                             2'b01, c[4:2], OPCODE_LOAD};
          // c.sw
          3'b110: instr_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                             c[11:10], c[6], 2'b00, OPCODE_STORE};
          default: illegal_o = 1'b1;
        endcase
      end
      ////////////////////////////////////////////////////////////
      // quadrant 1
      ////////////////////////////////////////////////////////////
      2'b01: begin
        unique case (c[15:13])
          // c.addi / c.nop
          3'b000: instr_o = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OPIMM};
          // c.jal (001) and c.j (101) with rd picked by bit 15
          3'b001, 3'b101: instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                     {9{c[12]}}, 4'b0, ~c[15], OPCODE_JAL};
          // c.li
          3'b010: begin
            instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7], OPCODE_OPIMM};
            if (c[11:7] == 5'd0) illegal_o = 1'b1;
          end
          // c.lui or c.addi16sp when rd is sp
          3'b011: begin
            if (c[11:7] == 5'd2) begin
              instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'd2, 3'b000,
                         5'd2, OPCODE_OPIMM};
            end else begin
              instr_o = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
            end
            if (c[11:7] == 5'd0 || {c[12], c[6:2]} == 6'd0) illegal_o = 1'b1;
          end
          3'b100: begin
            unique case (c[11:10])
              // c.srli / c.srai need shamt[5] clear on rv32
              2'b00, 2'b01: begin
                instr_o = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101,
                           2'b01, c[9:7], OPCODE_OPIMM};
                if (c[12] || c[6:2] == 5'd0) illegal_o = 1'b1;
              end
              // c.andi
              2'b10: instr_o = {{7{c[12]}}, c[6:2], 2'b01, c[9:7], 3'b111,
                                2'b01, c[9:7], OPCODE_OPIMM};
              // register-register group
              default: begin
                unique case ({c[12], c[6:5]})
                  3'b000: instr_o = {7'h20, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                                     2'b01, c[9:7], OPCODE_OP};
                  3'b001: instr_o = {7'h00, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100,
                                     2'b01, c[9:7], OPCODE_OP};
                  3'b010: instr_o = {7'h00, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110,
                                     2'b01, c[9:7], OPCODE_OP};
                  3'b011: instr_o = {7'h00, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111,
                                     2'b01, c[9:7], OPCODE_OP};
                  // c.subw c.addw and reserved forms do not exist on rv32
                  default: illegal_o = 1'b1;
                endcase
              end
            endcase
          end
          // c.beqz (110) / c.bnez (111) take funct3 low bit from bit 13
          default: instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7], 2'b00, c[13],
                              c[11:10], c[4:3], c[12], OPCODE_BRANCH};
        endcase
      end
      ////////////////////////////////////////////////////////////
      // quadrant 2
      ////////////////////////////////////////////////////////////
      2'b10: begin
        unique case (c[15:13])
          // c.slli
          3'b000: begin
            instr_o = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPCODE_OPIMM};
            if (c[11:7] == 5'd0 || c[12] || c[6:2] == 5'd0) illegal_o = 1'b1;
          end
          // c.lwsp with rd x0 is reserved
          3'b010: begin
            instr_o = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                       OPCODE_LOAD};
            if (c[11:7] == 5'd0) illegal_o = 1'b1;
          end
          3'b100: begin
            if (!c[12]) begin
              if (c[6:2] == 5'd0) begin
                // c.jr with rs1 x0 is reserved
                instr_o = {12'd0, c[11:7], 3'b000, 5'd0, OPCODE_JALR};
                if (c[11:7] == 5'd0) illegal_o = 1'b1;
              end else begin
                // c.mv
                instr_o = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], OPCODE_OP};
              end
            end else if (c[6:2] == 5'd0) begin
              // c.ebreak with rd x0 and c.jalr otherwise
              if (c[11:7] == 5'd0) instr_o = 32'h0010_0073;
              else instr_o = {12'd0, c[11:7], 3'b000, 5'd1, OPCODE_JALR};
            end else begin
              // c.add with rd x0 is a hint and stays legal
              instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OP};
            end
          end
          // c.swsp
          3'b110: instr_o = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00,
                             OPCODE_STORE};
          default: illegal_o = 1'b1;
        endcase
      end
      // full 32-bit word passes through
      default: instr_o = instr_i;
    endcase
  end
endmodule

/* design/rvc_decode.sv */
`timescale 1ns/1ns

module rvc_decode (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 issue_i,
  input  logic [31:0]          instr_i,
  output logic                 dec_valid_o,
  output rvc_pkg::dec_payload_t dec_payload_o
);
  import rvc_pkg::*;

  logic [31:0]  ex_instr;
  logic         ex_compressed;
  logic         ex_illegal;
  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  dec_payload_t dec_d;

  rvc_expand u_expand (
    .instr_i        (instr_i),
    .instr_o        (ex_instr),
    .is_compressed_o(ex_compressed),
    .illegal_o      (ex_illegal)
  );

  assign opcode = ex_instr[6:0];
  assign funct3 = ex_instr[14:12];
  assign funct7 = ex_instr[31:25];

  ////////////////////////////////////////////////////////////
  // classify and build payload
  ////////////////////////////////////////////////////////////
  always_comb begin
    dec_d         = '0;
    dec_d.rd      = ex_instr[11:7];
    dec_d.rs1     = ex_instr[19:15];
    dec_d.rs2     = ex_instr[24:20];
    dec_d.imm     = {{20{ex_instr[31]}}, ex_instr[31:20]};
    dec_d.b_imm   = (opcode == OPCODE_OPIMM);
    // funct3 maps straight onto the alu and bit 30 picks sub/sra
    unique case (funct3)
      3'b000:  dec_d.alu_op = (opcode == OPCODE_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  dec_d.alu_op = ALU_SLL;
      3'b010:  dec_d.alu_op = ALU_SLT;
      3'b011:  dec_d.alu_op = ALU_SLTU;
      3'b100:  dec_d.alu_op = ALU_XOR;
      3'b101:  dec_d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  dec_d.alu_op = ALU_OR;
      default: dec_d.alu_op = ALU_AND;
    endcase
    unique case (opcode)
      OPCODE_OPIMM: begin
        // shift immediates only allow funct7 0 or 0x20 (srai)
        if (funct3 == 3'b001 && funct7 != 7'h00) dec_d.illegal = 1'b1;
        if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) dec_d.illegal = 1'b1;
      end
      OPCODE_OP: begin
        if (funct7 == 7'h01) dec_d.unsup = 1'b1;   // m extension
        else if (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)) dec_d.unsup = 1'b0;
        else if (funct7 != 7'h00) dec_d.illegal = 1'b1;
      end
      OPCODE_LUI: begin
        dec_d.alu_op = ALU_PASS_B;
        dec_d.b_imm  = 1'b1;
        dec_d.imm    = {ex_instr[31:12], 12'd0};
      end
      OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR, OPCODE_SYSTEM:
        dec_d.unsup = 1'b1;
      default: dec_d.illegal = 1'b1;
    endcase
    // compressed words must arrive with a clean upper half
    if (ex_illegal || (ex_compressed && instr_i[31:16] != 16'd0)) begin
      dec_d.illegal = 1'b1;
    end
    if (dec_d.illegal) dec_d.unsup = 1'b0;
    dec_d.we = !dec_d.illegal && !dec_d.unsup && (dec_d.rd != 5'd0);
  end

  // valid follows issue and the payload only loads on issue
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) dec_valid_o <= 1'b0;
    else dec_valid_o <= issue_i;
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) dec_payload_o <= dec_d;
  end
endmodule

/* design/rvc_execute.sv */
`timescale 1ns/1ns

module rvc_execute (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  dec_valid_i,
  input  rvc_pkg::dec_payload_t dec_payload_i,
  rf_read_if.exe                rf,
  input  logic                  byp_valid_i,
  input  rvc_pkg::exe_payload_t byp_payload_i,
  output logic                  exe_valid_o,
  output rvc_pkg::exe_payload_t exe_payload_o
);
  import rvc_pkg::*;

  logic         byp_rs1;
  logic         byp_rs2;
  logic [31:0]  op_a;
  logic [31:0]  rs2_val;
  logic [31:0]  op_b;
  logic [4:0]   shamt;
  logic [31:0]  alu_res;
  exe_payload_t exe_d;

  assign rf.rs1_addr = dec_payload_i.rs1;
  assign rf.rs2_addr = dec_payload_i.rs2;

  ////////////////////////////////////////////////////////////
  // operand select
  ////////////////////////////////////////////////////////////
  // forward the result stage value before it is written back
  // we is never set for rd x0 so x0 never gets forwarded
  assign byp_rs1 = byp_valid_i && byp_payload_i.we && (byp_payload_i.rd == dec_payload_i.rs1);
  assign byp_rs2 = byp_valid_i && byp_payload_i.we && (byp_payload_i.rd == dec_payload_i.rs2);

  assign op_a    = byp_rs1 ? byp_payload_i.result : rf.rs1_data;
  assign rs2_val = byp_rs2 ? byp_payload_i.result : rf.rs2_data;
  assign op_b    = dec_payload_i.b_imm ? dec_payload_i.imm : rs2_val;
  assign shamt   = op_b[4:0];

  // alu
  always_comb begin
    unique case (dec_payload_i.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'd0, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_b;   // pass-b for lui
    endcase
  end

  always_comb begin
    exe_d.rd      = dec_payload_i.rd;
    exe_d.result  = alu_res;
    exe_d.we      = dec_payload_i.we;
    exe_d.illegal = dec_payload_i.illegal;
    exe_d.unsup   = dec_payload_i.unsup;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) exe_valid_o <= 1'b0;
    else exe_valid_o <= dec_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) exe_payload_o <= exe_d;
  end
endmodule

/* design/rvc_result.sv */
`timescale 1ns/1ns

module rvc_result (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  exe_valid_i,
  input  rvc_pkg::exe_payload_t exe_payload_i,
  rf_read_if.rf                 rf,
  input  logic [4:0]            host_addr_i,
  output logic [31:0]           host_data_o,
  output logic [31:0]           status_o
);
  import rvc_pkg::*;

  logic [31:0] regs_q [32];
  logic [15:0] ill_cnt_q;
  logic [15:0] uns_cnt_q;

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////
  // all registers come out of reset as zero
  // decode never sets we for rd x0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) regs_q[i] <= '0;
    end else if (exe_valid_i && exe_payload_i.we) begin
      regs_q[exe_payload_i.rd] <= exe_payload_i.result;
    end
  end

  // x0 reads as zero on every port
  assign rf.rs1_data  = (rf.rs1_addr == 5'd0) ? 32'd0 : regs_q[rf.rs1_addr];
  assign rf.rs2_data  = (rf.rs2_addr == 5'd0) ? 32'd0 : regs_q[rf.rs2_addr];
  assign host_data_o  = (host_addr_i == 5'd0) ? 32'd0 : regs_q[host_addr_i];

  ////////////////////////////////////////////////////////////
  // status counters
  ////////////////////////////////////////////////////////////
  // saturate at all ones instead of wrapping
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ill_cnt_q <= '0;
      uns_cnt_q <= '0;
    end else if (exe_valid_i) begin
      if (exe_payload_i.illegal && ill_cnt_q != 16'hffff) ill_cnt_q <= ill_cnt_q + 16'd1;
      if (exe_payload_i.unsup && uns_cnt_q != 16'hffff) uns_cnt_q <= uns_cnt_q + 16'd1;
    end
  end

  // illegal count in the high half and unsupported count in the low half
  assign status_o = {ill_cnt_q, uns_cnt_q};
endmodule

/* design/rvc_core_top.sv */
`timescale 1ns/1ns

module rvc_core_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [rvc_pkg::ADR_W-1:0] wb_adr_i,
  input  logic [31:0]              wb_dat_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o
);
  import rvc_pkg::*;

  logic         ack_q;
  logic         pend_q;
  logic         req;
  logic         do_ack;
  logic         issue;
  logic         pipe_busy;
  logic [31:0]  rd_data;
  logic [31:0]  host_data;
  logic [31:0]  status;
  logic         dec_valid;
  dec_payload_t dec_payload;
  logic         exe_valid;
  exe_payload_t exe_payload;

  rf_read_if rd_if ();

  ////////////////////////////////////////////////////////////
  // wishbone classic slave
  ////////////////////////////////////////////////////////////
  // first cycle of a request only marks it pending
  // writes ack on the next edge and reads wait for an empty pipeline
  assign req       = wb_cyc_i && wb_stb_i && !ack_q;
  assign pipe_busy = dec_valid || exe_valid;
  assign do_ack    = req && pend_q && (wb_we_i || !pipe_busy);
  assign issue     = do_ack && wb_we_i && (wb_adr_i == ADR_INSTR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      ack_q  <= do_ack;
      pend_q <= req && !do_ack;
    end
  end

  // address decode for reads
  always_comb begin
    if (!wb_adr_i[5]) rd_data = host_data;
    else if (wb_adr_i == ADR_STATUS) rd_data = status;
    else rd_data = 32'd0;
  end

  always_ff @(posedge clk_i) begin
    if (do_ack && !wb_we_i) wb_dat_o <= rd_data;
  end

  assign wb_ack_o = ack_q;

  // stages with the result payload looped back as the bypass
  rvc_decode u_decode (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .issue_i(issue), .instr_i(wb_dat_i),
    .dec_valid_o(dec_valid), .dec_payload_o(dec_payload)
  );

  rvc_execute u_execute (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .dec_valid_i(dec_valid),
    .dec_payload_i(dec_payload), .rf(rd_if.exe), .byp_valid_i(exe_valid),
    .byp_payload_i(exe_payload), .exe_valid_o(exe_valid), .exe_payload_o(exe_payload)
  );

  rvc_result u_result (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .exe_valid_i(exe_valid),
    .exe_payload_i(exe_payload), .rf(rd_if.rf), .host_addr_i(wb_adr_i[4:0]),
    .host_data_o(host_data), .status_o(status)
  );
endmodule

/* test/rvc_core_chk.sv */
`timescale 1ns/1ns

// wishbone slave rules bound onto rvc_core_top
module rvc_core_chk (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic                      wb_we_i,
  input logic [rvc_pkg::ADR_W-1:0] wb_adr_i,
  input logic [31:0]               wb_dat_o,
  input logic                      wb_ack_o
);
  // ack only answers a live request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i)) else $error("ack without cyc and stb");

  // single cycle ack
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o) else $error("ack high for two cycles");

  // quiet bus while in reset
  ack_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !wb_ack_o) else $error("ack during reset");

  // x0 is hard-wired
  x0_reads_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_ack_o && !wb_we_i && wb_adr_i == '0) |-> (wb_dat_o == 32'd0))
    else $error("read of x0 not zero");
endmodule

/* test/tb_rvc_core.sv */
`timescale 1ns/1ns

module tb_rvc_core;
  import rvc_pkg::*;

  localparam int N_C = 150;
  localparam int N_M = 150;
  // upper bound on bus transactions over all phases
  localparam int MAX_TRANS = 33 * 5 + N_C * 2 + N_M * 3 + 15;
  localparam int CYCLE_LIMIT = 20 * MAX_TRANS;

  logic             clk_i;
  logic             arst_n_i;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_we_i;
  logic [ADR_W-1:0] wb_adr_i;
  logic [31:0]      wb_dat_i;
  logic [31:0]      wb_dat_o;
  logic             wb_ack_o;

  integer      seed;
  int          cycles = 0;
  int          n_err = 0;
  logic [31:0] model [32];
  logic [15:0] exp_ill;
  logic [15:0] exp_uns;
  logic [4:0]  last_rd;

  rvc_core_top dut0 (.*);

  bind rvc_core_top rvc_core_chk u_chk (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // watchdog for a missing ack
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: no wishbone ack within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // mostly x8..x15 so compressed forms collide often
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = rand32();
    if (r[1:0] != 2'b00) pick_reg = {2'b01, r[4:2]};
    else pick_reg = r[9:5];
  endfunction

  function automatic void set_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) model[rd] = val;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // one classic cycle entered and left on a falling edge
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do @(negedge clk_i); while (!wb_ack_o);
    rdat = wb_dat_o;
    // hold through the edge where ack is sampled
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic issue(input logic [31:0] w);
    logic [31:0] d;
    bus_cycle(1'b1, ADR_INSTR, w, d);
  endtask

  task automatic check_regs();
    logic [31:0] d;
    for (int i = 0; i < 32; i++) begin
      bus_cycle(1'b0, 6'(i), 32'd0, d);
      check_eq(d, model[i], $sformatf("x%0d", i));
    end
    bus_cycle(1'b0, ADR_STATUS, 32'd0, d);
    check_eq(d, {exp_ill, exp_uns}, "status word");
  endtask

  task automatic maybe_read();
    logic [31:0] r;
    logic [31:0] d;
    logic [4:0]  rs;
    r = rand32();
    if (r[1:0] == 2'b00) begin
      rs = pick_reg();
      bus_cycle(1'b0, {1'b0, rs}, 32'd0, d);
      check_eq(d, model[rs], $sformatf("x%0d after issue", rs));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // random instruction generators with model update
  ////////////////////////////////////////////////////////////
  task automatic random_rvc();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  xd;
    logic [4:0]  xs;
    logic [5:0]  imm;
    logic [4:0]  sh;
    logic [31:0] simm;
    logic [15:0] c;
    int          k;
    r   = rand32();
    xd  = {2'b01, r[2:0]};
    xs  = {2'b01, r[5:3]};
    imm = (r[11:6] == 6'd0) ? 6'd1 : r[11:6];
    sh  = (imm[4:0] == 5'd0) ? 5'd1 : imm[4:0];
    simm = {{26{imm[5]}}, imm};
    k   = r[31:16] % 16'd13;
    // rd x0 and x2 are reserved for c.li, c.lui and c.slli
    do rd = pick_reg(); while (rd == 5'd0 || rd == 5'd2);
    do rs = pick_reg(); while (rs == 5'd0);
    case (k)
      0: begin
        c = {3'b010, imm[5], rd, imm[4:0], 2'b01};
        set_reg(rd, simm);
      end
      1: begin
        c = {3'b011, imm[5], rd, imm[4:0], 2'b01};
        set_reg(rd, simm << 12);
      end
      2: begin
        c = {3'b000, imm[5], rd, imm[4:0], 2'b01};
        set_reg(rd, model[rd] + simm);
      end
      3: begin
        c = {3'b100, imm[5], 2'b10, xd[2:0], imm[4:0], 2'b01};
        set_reg(xd, model[xd] & simm);
      end
      4: begin
        c = {3'b000, 1'b0, rd, sh, 2'b10};
        set_reg(rd, model[rd] << sh);
      end
      5: begin
        c = {3'b100, 1'b0, 2'b00, xd[2:0], sh, 2'b01};
        set_reg(xd, model[xd] >> sh);
      end
      6: begin
        c = {3'b100, 1'b0, 2'b01, xd[2:0], sh, 2'b01};
        set_reg(xd, $unsigned($signed(model[xd]) >>> sh));
      end
      7: begin
        c = {6'b100011, xd[2:0], 2'b00, xs[2:0], 2'b01};
        set_reg(xd, model[xd] - model[xs]);
      end
      8: begin
        c = {6'b100011, xd[2:0], 2'b01, xs[2:0], 2'b01};
        set_reg(xd, model[xd] ^ model[xs]);
      end
      9: begin
        c = {6'b100011, xd[2:0], 2'b10, xs[2:0], 2'b01};
        set_reg(xd, model[xd] | model[xs]);
      end
      10: begin
        c = {6'b100011, xd[2:0], 2'b11, xs[2:0], 2'b01};
        set_reg(xd, model[xd] & model[xs]);
      end
      11: begin
        c = {3'b100, 1'b0, rd, rs, 2'b10};
        set_reg(rd, model[rs]);
      end
      default: begin
        c = {3'b100, 1'b1, rd, rs, 2'b10};
        set_reg(rd, model[rd] + model[rs]);
      end
    endcase
    issue({16'd0, c});
  endtask

  // dep forces rs1 onto the previous rd
  task automatic random_rv32(input logic dep, input logic [4:0] dep_reg);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a;
    logic [31:0] b;
    r   = rand32();
    rd  = pick_reg();
    rs2 = pick_reg();
    if (dep) rs1 = dep_reg;
    else rs1 = pick_reg();
    a = model[rs1];
    b = model[rs2];
    case (r[2:0])
      3'd0: begin
        issue({r[31:20], rs1, 3'b000, rd, OPCODE_OPIMM});
        set_reg(rd, a + {{20{r[31]}}, r[31:20]});
      end
      3'd1: begin
        issue({7'h00, rs2, rs1, 3'b000, rd, OPCODE_OP});
        set_reg(rd, a + b);
      end
      3'd2: begin
        issue({7'h20, rs2, rs1, 3'b000, rd, OPCODE_OP});
        set_reg(rd, a - b);
      end
      3'd3: begin
        issue({7'h00, rs2, rs1, 3'b010, rd, OPCODE_OP});
        set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      end
      3'd4: begin
        issue({7'h00, rs2, rs1, 3'b011, rd, OPCODE_OP});
        set_reg(rd, (a < b) ? 32'd1 : 32'd0);
      end
      3'd5: begin
        issue({7'h00, rs2, rs1, 3'b001, rd, OPCODE_OP});
        set_reg(rd, a << b[4:0]);
      end
      default: begin
        issue({r[31:12], rd, OPCODE_LUI});
        set_reg(rd, {r[31:12], 12'd0});
      end
    endcase
    last_rd = rd;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    arst_n_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    seed     = 47465;
    exp_ill  = '0;
    exp_uns  = '0;
    last_rd  = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    #5 arst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_regs();
    // compressed alu mix
    for (int i = 0; i < N_C; i++) begin
      random_rvc();
      maybe_read();
    end
    // mixed widths with dependent pairs
    for (int i = 0; i < N_M; i++) begin
      r = rand32();
      if (r[0]) random_rvc();
      else random_rv32(1'b0, 5'd0);
      if (!r[0] && r[2:1] == 2'b00) random_rv32(1'b1, last_rd);
      maybe_read();
    end
    check_regs();
    // writes aimed at x0 by c.add, addi, c.mv and add
    issue({16'd0, 3'b100, 1'b1, 5'd0, 5'd9, 2'b10});
    issue({12'h123, 5'd5, 3'b000, 5'd0, OPCODE_OPIMM});
    issue({16'd0, 3'b100, 1'b0, 5'd0, 5'd10, 2'b10});
    issue({7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OPCODE_OP});
    check_regs();
    // illegal c.addi4spn zero imm, c.lwsp x0, zero halfword and c.subw
    issue(32'h0000_0004);
    issue({16'd0, 3'b010, 1'b0, 5'd0, 5'b00100, 2'b10});
    issue(32'h0000_0000);
    issue({16'd0, 6'b100111, 3'b001, 2'b00, 3'b010, 2'b01});
    exp_ill = exp_ill + 16'd4;
    check_regs();
    // decoded but not executed: c.lw c.sw c.j c.beqz c.jr c.ebreak mul
    issue({16'd0, 3'b010, 3'b000, 3'b001, 2'b00, 3'b001, 2'b00});
    issue({16'd0, 3'b110, 3'b000, 3'b001, 2'b10, 3'b010, 2'b00});
    issue({16'd0, 3'b101, 11'h004, 2'b01});
    issue({16'd0, 3'b110, 3'b000, 3'b000, 5'b00100, 2'b01});
    issue({16'd0, 3'b100, 1'b0, 5'd1, 5'd0, 2'b10});
    issue(32'h0000_9002);
    issue({7'h01, 5'd7, 5'd6, 3'b000, 5'd5, OPCODE_OP});
    exp_uns = exp_uns + 16'd7;
    check_regs();
    if (n_err == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end
endmodule

/* project.f */
design/rvc_pkg.sv
design/rf_read_if.sv
design/rvc_expand.sv
design/rvc_decode.sv
design/rvc_execute.sv
design/rvc_result.sv
design/rvc_core_top.sv
test/rvc_core_chk.sv
test/tb_rvc_core.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rvc_core \
  -f project.f -o sim_rvc_core > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_rvc_core > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0
